// ==== hw/ex_consts.svh ====
// widths and encodings for an RV32-only execute stage
// jump targets must be word aligned since compressed targets are not supported
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// ------------------------------------------------------------
// widths
// ------------------------------------------------------------
`define EX_XLEN      32
`define EX_REG_AW    5
`define EX_ALUOP_W   4
`define EX_FUNCT3_W  3
`define EX_SHAMT_W   5
`define EX_ZONE_W    2
`define EX_EXCP_W    2

// ------------------------------------------------------------
// alu opcodes
// ------------------------------------------------------------
`define EX_ALU_ADD   4'd0
`define EX_ALU_SUB   4'd1
`define EX_ALU_AND   4'd2
`define EX_ALU_OR    4'd3
`define EX_ALU_XOR   4'd4
`define EX_ALU_SLL   4'd5
`define EX_ALU_SRL   4'd6
`define EX_ALU_SRA   4'd7
`define EX_ALU_SLT   4'd8
`define EX_ALU_SLTU  4'd9

// branch compare codes, as in the RISC-V funct3 field
`define EX_F3_BEQ    3'b000
`define EX_F3_BNE    3'b001
`define EX_F3_BLT    3'b100
`define EX_F3_BGE    3'b101
`define EX_F3_BLTU   3'b110
`define EX_F3_BGEU   3'b111

// memory access size
`define EX_F3_HALF   3'b001
`define EX_F3_WORD   3'b010

// destination zones
`define EX_ZONE_NONE     2'd0
`define EX_ZONE_REGFILE  2'd1
`define EX_ZONE_LOADQ    2'd2
`define EX_ZONE_STOREQ   2'd3

// exception causes
`define EX_EXCP_NONE     2'd0
`define EX_EXCP_FETCH    2'd1
`define EX_EXCP_LOAD     2'd2
`define EX_EXCP_STORE    2'd3

`endif

// ==== hw/ex_pkg.sv ====
// types shared across the execute stage
// enum values follow the encodings in ex_consts.svh
`include "ex_consts.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0] xword_t;

    typedef enum logic [`EX_ALUOP_W-1:0] {
        ALU_ADD  = `EX_ALU_ADD,
        ALU_SUB  = `EX_ALU_SUB,
        ALU_AND  = `EX_ALU_AND,
        ALU_OR   = `EX_ALU_OR,
        ALU_XOR  = `EX_ALU_XOR,
        ALU_SLL  = `EX_ALU_SLL,
        ALU_SRL  = `EX_ALU_SRL,
        ALU_SRA  = `EX_ALU_SRA,
        ALU_SLT  = `EX_ALU_SLT,
        ALU_SLTU = `EX_ALU_SLTU
    } alu_op_e;

    typedef enum logic [`EX_ZONE_W-1:0] {
        ZONE_NONE    = `EX_ZONE_NONE,
        ZONE_REGFILE = `EX_ZONE_REGFILE,
        ZONE_LOADQ   = `EX_ZONE_LOADQ,
        ZONE_STOREQ  = `EX_ZONE_STOREQ
    } zone_e;

    typedef enum logic [`EX_EXCP_W-1:0] {
        EXCP_NONE           = `EX_EXCP_NONE,
        EXCP_FETCH_MISALIGN = `EX_EXCP_FETCH,
        EXCP_LOAD_MISALIGN  = `EX_EXCP_LOAD,
        EXCP_STORE_MISALIGN = `EX_EXCP_STORE
    } excp_cause_e;

    // ------------------------------------------------------------
    // decoder request and its registered control part
    // ------------------------------------------------------------
    typedef struct packed {
        logic                    valid;
        logic                    sof;
        xword_t                  pc;
        logic [1:0]              ins_size;
        zone_e                   zone;
        logic                    jump;
        logic                    cond;
        logic                    link;
        alu_op_e                 alu_op;
        xword_t                  operand_left;
        xword_t                  operand_right;
        xword_t                  cmp_left;
        xword_t                  cmp_right;
        xword_t                  regs2_data;
        logic [`EX_REG_AW-1:0]   regd_addr;
        logic [`EX_FUNCT3_W-1:0] funct3;
    } ex_req_t;

    typedef struct packed {
        logic                    valid;
        zone_e                   zone;
        logic                    jump;
        logic                    cond;
        logic                    link;
        xword_t                  pc_inc;
        xword_t                  regs2_data;
        logic [`EX_REG_AW-1:0]   regd_addr;
        logic [`EX_FUNCT3_W-1:0] funct3;
    } ex_ctrl_t;

    typedef struct packed {
        xword_t result;
        logic   cmp;
    } alu_res_t;

    // ------------------------------------------------------------
    // commit outputs
    // ------------------------------------------------------------
    typedef struct packed {
        logic                  wr;
        logic                  cancel_load;
        logic [`EX_REG_AW-1:0] regd_addr;
        xword_t                data;
    } wb_t;

    typedef struct packed {
        logic                    lq_wr;
        logic                    sq_wr;
        logic [`EX_FUNCT3_W-1:0] funct3;
        logic [`EX_REG_AW-1:0]   regd_addr;
        xword_t                  data;
        xword_t                  addr;
    } lsq_req_t;

    typedef struct packed {
        logic   jump;
        xword_t jump_addr;
    } redirect_t;

endpackage

// ==== hw/ex_pipe_reg.sv ====
// pipeline register for any packed payload
// reset clears the whole payload, so all flags in it come up inactive
`timescale 1ns/1ps

module ex_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     resetb_i,
    input  logic     en_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // hold while disabled
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            q_o <= '0;
        end else if (en_i) begin
            q_o <= d_i;
        end
    end

endmodule

// ==== hw/ex_alu.sv ====
// ALU and branch comparator with both results registered when en_i is high
// shifts use only the low 5 bits of the right operand
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_alu (
    input  logic                    clk_i,
    input  logic                    resetb_i,
    input  logic                    en_i,
    input  ex_pkg::alu_op_e         op_i,
    input  ex_pkg::xword_t          left_i,
    input  ex_pkg::xword_t          right_i,
    input  ex_pkg::xword_t          cmp_left_i,
    input  ex_pkg::xword_t          cmp_right_i,
    input  logic [`EX_FUNCT3_W-1:0] funct3_i,
    output ex_pkg::alu_res_t        res_o
);

    import ex_pkg::*;

    logic [`EX_SHAMT_W-1:0] shamt;
    xword_t                 op_result;
    logic                   cmp_eq;
    logic                   cmp_lt;
    logic                   cmp_ltu;
    logic                   cmp_result;
    alu_res_t               res_d;

    // ------------------------------------------------------------
    // arithmetic and logic
    // ------------------------------------------------------------
    assign shamt = right_i[`EX_SHAMT_W-1:0];

    always_comb begin
        case (op_i)
            ALU_ADD  : op_result = left_i + right_i;
            ALU_SUB  : op_result = left_i - right_i;
            ALU_AND  : op_result = left_i & right_i;
            ALU_OR   : op_result = left_i | right_i;
            ALU_XOR  : op_result = left_i ^ right_i;
            ALU_SLL  : op_result = left_i << shamt;
            ALU_SRL  : op_result = left_i >> shamt;
            ALU_SRA  : op_result = $signed(left_i) >>> shamt;
            ALU_SLT  : op_result = xword_t'($signed(left_i) < $signed(right_i));
            ALU_SLTU : op_result = xword_t'(left_i < right_i);
            default  : op_result = '0;
        endcase
    end

    // ------------------------------------------------------------
    // branch compare
    // ------------------------------------------------------------
    assign cmp_eq  = (cmp_left_i == cmp_right_i);
    assign cmp_lt  = ($signed(cmp_left_i) < $signed(cmp_right_i));
    assign cmp_ltu = (cmp_left_i < cmp_right_i);

    always_comb begin
        case (funct3_i)
            `EX_F3_BEQ  : cmp_result = cmp_eq;
            `EX_F3_BNE  : cmp_result = ~cmp_eq;
            `EX_F3_BLT  : cmp_result = cmp_lt;
            `EX_F3_BGE  : cmp_result = ~cmp_lt;
            `EX_F3_BLTU : cmp_result = cmp_ltu;
            `EX_F3_BGEU : cmp_result = ~cmp_ltu;
            default     : cmp_result = 1'b0;
        endcase
    end

    assign res_d = '{result: op_result, cmp: cmp_result};

    // lines up with the control register of the same instruction
    ex_pipe_reg #(
        .payload_t (alu_res_t)
    ) alu_res_reg_inst (
        .clk_i    (clk_i),
        .resetb_i (resetb_i),
        .en_i     (en_i),
        .d_i      (res_d),
        .q_o      (res_o)
    );

endmodule

// ==== hw/ex_flow_fsm.sv ====
// discards wrong-path instructions after a redirect until one arrives with sof
// a redirect wins over a request with sof accepted on the same edge
`timescale 1ns/1ps

module ex_flow_fsm (
    input  logic clk_i,
    input  logic resetb_i,
    input  logic en_i,
    input  logic redirect_i,
    input  logic req_valid_i,
    input  logic req_sof_i,
    output logic run_o
);

    typedef enum logic {
        FLOW_RUN,
        FLOW_DISCARD
    } flow_state_e;

    flow_state_e state_q;
    flow_state_e state_d;

    always_comb begin
        state_d = state_q;
        if (redirect_i) begin
            state_d = FLOW_DISCARD;
        end else if (req_valid_i && req_sof_i) begin
            // first instruction of the new flow
            state_d = FLOW_RUN;
        end
    end

    // en_i low means the stage is stalled
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            state_q <= FLOW_RUN;
        end else if (en_i) begin
            state_q <= state_d;
        end
    end

    assign run_o = (state_q == FLOW_RUN);

endmodule

// ==== hw/ex_commit.sv ====
// purely combinational commit decision for the registered instruction
// only 001 (half) and 010 (word) funct3 codes are checked for misalignment
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_commit (
    input  ex_pkg::ex_ctrl_t    ctrl_i,
    input  ex_pkg::alu_res_t    alu_i,
    input  logic                run_i,
    input  logic                lsq_full_i,
    output logic                stall_o,
    output ex_pkg::wb_t         wb_o,
    output ex_pkg::lsq_req_t    lsq_o,
    output ex_pkg::redirect_t   redirect_o,
    output logic                excp_valid_o,
    output ex_pkg::excp_cause_e excp_cause_o
);

    import ex_pkg::*;

    logic        is_reg;
    logic        is_load;
    logic        is_store;
    logic        is_mem;
    logic        ex_valid;
    logic        taken;
    logic        mis_fetch;
    logic        mis_mem;
    logic        commit;
    logic        go;
    excp_cause_e cause;

    // ------------------------------------------------------------
    // qualification
    // ------------------------------------------------------------
    assign is_reg   = (ctrl_i.zone == ZONE_REGFILE);
    assign is_load  = (ctrl_i.zone == ZONE_LOADQ);
    assign is_store = (ctrl_i.zone == ZONE_STOREQ);
    assign is_mem   = is_load | is_store;

    // wrong-path instructions are dropped here
    assign ex_valid = ctrl_i.valid & run_i;
    assign taken    = alu_i.cmp | ~ctrl_i.cond;

    // ------------------------------------------------------------
    // misalignment
    // ------------------------------------------------------------
    assign mis_fetch = ctrl_i.jump & (|alu_i.result[1:0]);

    always_comb begin
        mis_mem = 1'b0;
        if (is_mem) begin
            case (ctrl_i.funct3)
                `EX_F3_HALF : mis_mem = alu_i.result[0];
                `EX_F3_WORD : mis_mem = |alu_i.result[1:0];
                default     : mis_mem = 1'b0;
            endcase
        end
    end

    always_comb begin
        if (mis_fetch) begin
            cause = EXCP_FETCH_MISALIGN;
        end else if (mis_mem && is_load) begin
            cause = EXCP_LOAD_MISALIGN;
        end else if (mis_mem) begin
            cause = EXCP_STORE_MISALIGN;
        end else begin
            cause = EXCP_NONE;
        end
    end

    // ------------------------------------------------------------
    // commit and stall
    // ------------------------------------------------------------
    assign commit  = ex_valid & taken & ~mis_fetch & ~mis_mem;
    assign stall_o = commit & is_mem & lsq_full_i;
    assign go      = ~stall_o;

    // not-taken branches never trap on their target
    assign excp_valid_o = go & ex_valid & taken & (mis_fetch | mis_mem);
    assign excp_cause_o = excp_valid_o ? cause : EXCP_NONE;

    always_comb begin
        // link writes the return address to the register file
        wb_o.wr          = go & commit & is_reg;
        wb_o.cancel_load = go & ctrl_i.valid & is_load & ~commit;
        wb_o.regd_addr   = ctrl_i.regd_addr;
        wb_o.data        = ctrl_i.link ? ctrl_i.pc_inc : alu_i.result;

        // load/store queue
        lsq_o.lq_wr      = go & commit & is_load;
        lsq_o.sq_wr      = go & commit & is_store;
        lsq_o.funct3     = ctrl_i.funct3;
        lsq_o.regd_addr  = ctrl_i.regd_addr;
        lsq_o.data       = ctrl_i.regs2_data;
        lsq_o.addr       = alu_i.result;

        // fetch redirect
        redirect_o.jump      = go & commit & ctrl_i.jump;
        redirect_o.jump_addr = alu_i.result;
    end

endmodule

// ==== hw/ex_stage_top.sv ====
// commit outputs come one cycle after acceptance when there is no stall
// the decoder must hold its request while ids_stall_o is high
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage_top (
    input  logic                clk_i,
    input  logic                resetb_i,
    input  ex_pkg::ex_req_t     ids_req_i,
    output logic                ids_stall_o,
    input  logic                lsq_full_i,
    output ex_pkg::wb_t         wb_o,
    output ex_pkg::lsq_req_t    lsq_o,
    output ex_pkg::redirect_t   redirect_o,
    output logic                excp_valid_o,
    output ex_pkg::excp_cause_e excp_cause_o
);

    import ex_pkg::*;

    logic     stage_en;
    logic     run;
    xword_t   pc_inc;
    ex_ctrl_t ctrl_d;
    ex_ctrl_t ctrl_q;
    alu_res_t alu_q;

    assign stage_en = ~ids_stall_o;

    // ------------------------------------------------------------
    // control payload
    // ------------------------------------------------------------
    // ins_size counts halfwords
    assign pc_inc = ids_req_i.pc + {{(`EX_XLEN-3){1'b0}}, ids_req_i.ins_size, 1'b0};

    assign ctrl_d = '{
        valid:      ids_req_i.valid,
        zone:       ids_req_i.zone,
        jump:       ids_req_i.jump,
        cond:       ids_req_i.cond,
        link:       ids_req_i.link,
        pc_inc:     pc_inc,
        regs2_data: ids_req_i.regs2_data,
        regd_addr:  ids_req_i.regd_addr,
        funct3:     ids_req_i.funct3
    };

    ex_pipe_reg #(
        .payload_t (ex_ctrl_t)
    ) ctrl_reg_inst (
        .clk_i    (clk_i),
        .resetb_i (resetb_i),
        .en_i     (stage_en),
        .d_i      (ctrl_d),
        .q_o      (ctrl_q)
    );

    // ------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------
    ex_alu alu_inst (
        .clk_i       (clk_i),
        .resetb_i    (resetb_i),
        .en_i        (stage_en),
        .op_i        (ids_req_i.alu_op),
        .left_i      (ids_req_i.operand_left),
        .right_i     (ids_req_i.operand_right),
        .cmp_left_i  (ids_req_i.cmp_left),
        .cmp_right_i (ids_req_i.cmp_right),
        .funct3_i    (ids_req_i.funct3),
        .res_o       (alu_q)
    );

    // ------------------------------------------------------------
    // flow control and commit
    // ------------------------------------------------------------
    ex_flow_fsm flow_fsm_inst (
        .clk_i       (clk_i),
        .resetb_i    (resetb_i),
        .en_i        (stage_en),
        .redirect_i  (redirect_o.jump),
        .req_valid_i (ids_req_i.valid),
        .req_sof_i   (ids_req_i.sof),
        .run_o       (run)
    );

    ex_commit commit_inst (
        .ctrl_i       (ctrl_q),
        .alu_i        (alu_q),
        .run_i        (run),
        .lsq_full_i   (lsq_full_i),
        .stall_o      (ids_stall_o),
        .wb_o         (wb_o),
        .lsq_o        (lsq_o),
        .redirect_o   (redirect_o),
        .excp_valid_o (excp_valid_o),
        .excp_cause_o (excp_cause_o)
    );

endmodule

// ==== verification/ex_stage_tb.sv ====
// drives the execute stage with random requests from a fixed-seed LCG
// expected commits come from a reference model and are checked at unstalled rising edges
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage_tb;

    import ex_pkg::*;

    localparam int CLK_HALF     = 50;
    localparam int ACCEPT_LIMIT = 100;

    typedef struct packed {
        wb_t         wb;
        lsq_req_t    lsq;
        redirect_t   rd;
        logic        excp_valid;
        excp_cause_e excp_cause;
    } exp_t;

    logic        clk_i;
    logic        resetb_i;
    ex_req_t     ids_req_i;
    logic        ids_stall_o;
    logic        lsq_full_i;
    wb_t         wb_o;
    lsq_req_t    lsq_o;
    redirect_t   redirect_o;
    logic        excp_valid_o;
    excp_cause_e excp_cause_o;

    logic [31:0] lcg_state;
    exp_t        expq[$];
    int          errors;
    int          checks;
    int          err_mark;
    int          chk_mark;
    int          stall_cycles;
    int          wb_writes;
    // reference flow state
    logic        model_run;
    logic        model_redirect;

    ex_stage_top ex_stage_top_inst (
        .clk_i        (clk_i),
        .resetb_i     (resetb_i),
        .ids_req_i    (ids_req_i),
        .ids_stall_o  (ids_stall_o),
        .lsq_full_i   (lsq_full_i),
        .wb_o         (wb_o),
        .lsq_o        (lsq_o),
        .redirect_o   (redirect_o),
        .excp_valid_o (excp_valid_o),
        .excp_cause_o (excp_cause_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #CLK_HALF clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // random source and reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic ex_req_t rand_req();
        ex_req_t     r;
        logic [31:0] w;
        r = '0;
        w = lcg_next();
        r.valid = 1'b1;
        r.sof = 1'b1;
        r.pc = lcg_next() & 32'hffff_fffc;
        r.ins_size = 2'd2;
        r.operand_left = lcg_next();
        r.operand_right = lcg_next();
        r.cmp_left = lcg_next();
        r.cmp_right = lcg_next();
        r.regs2_data = lcg_next();
        r.regd_addr = w[31:27];
        return r;
    endfunction

    function automatic logic [2:0] branch_code(input int k);
        case (k % 6)
            0: return `EX_F3_BEQ;
            1: return `EX_F3_BNE;
            2: return `EX_F3_BLT;
            3: return `EX_F3_BGE;
            4: return `EX_F3_BLTU;
            default: return `EX_F3_BGEU;
        endcase
    endfunction

    function automatic xword_t alu_model(input alu_op_e op, input xword_t a, input xword_t b);
        logic [4:0]  sh;
        logic [63:0] ext;
        sh = b[4:0];
        ext = {{32{a[31]}}, a};
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return ext[31:0] >> sh | ((ext >> sh) & 64'hffff_ffff);
            // when signs differ the negative one is smaller
            ALU_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            ALU_SLTU: return {31'd0, a < b};
            default:  return '0;
        endcase
    endfunction

    function automatic logic cmp_model(input logic [2:0] f3, input xword_t a, input xword_t b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (f3)
            `EX_F3_BEQ:  return a == b;
            `EX_F3_BNE:  return a != b;
            `EX_F3_BLT:  return sa < sb;
            `EX_F3_BGE:  return sa >= sb;
            `EX_F3_BLTU: return a < b;
            `EX_F3_BGEU: return a >= b;
            default:     return 1'b0;
        endcase
    endfunction

    function automatic exp_t ref_commit(input ex_req_t r);
        exp_t   e;
        xword_t res;
        logic   is_load;
        logic   is_store;
        logic   live;
        logic   taken;
        logic   mis_f;
        logic   mis_m;
        logic   commit;
        // the first request after a redirect is dropped even with sof
        if (model_redirect) begin
            model_run = 1'b0;
        end else if (r.valid && r.sof) begin
            model_run = 1'b1;
        end
        res = alu_model(r.alu_op, r.operand_left, r.operand_right);
        is_load = (r.zone == ZONE_LOADQ);
        is_store = (r.zone == ZONE_STOREQ);
        live = r.valid && model_run;
        taken = !r.cond || cmp_model(r.funct3, r.cmp_left, r.cmp_right);
        mis_f = r.jump && (res[1:0] != 2'b00);
        mis_m = (is_load || is_store) &&
                ((r.funct3 == `EX_F3_HALF && res[0]) ||
                 (r.funct3 == `EX_F3_WORD && res[1:0] != 2'b00));
        commit = live && taken && !mis_f && !mis_m;
        e = '0;
        e.wb.wr = commit && (r.zone == ZONE_REGFILE);
        e.wb.cancel_load = r.valid && is_load && !commit;
        e.wb.regd_addr = r.regd_addr;
        e.wb.data = r.link ? r.pc + 2 * r.ins_size : res;
        e.lsq.lq_wr = commit && is_load;
        e.lsq.sq_wr = commit && is_store;
        e.lsq.funct3 = r.funct3;
        e.lsq.regd_addr = r.regd_addr;
        e.lsq.data = r.regs2_data;
        e.lsq.addr = res;
        e.rd.jump = commit && r.jump;
        e.rd.jump_addr = res;
        e.excp_valid = live && taken && (mis_f || mis_m);
        if (!e.excp_valid) begin
            e.excp_cause = EXCP_NONE;
        end else if (mis_f) begin
            e.excp_cause = EXCP_FETCH_MISALIGN;
        end else if (is_load) begin
            e.excp_cause = EXCP_LOAD_MISALIGN;
        end else begin
            e.excp_cause = EXCP_STORE_MISALIGN;
        end
        model_redirect = e.rd.jump;
        return e;
    endfunction

    // ------------------------------------------------------------
    // checking
    // ------------------------------------------------------------
    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_commit(input exp_t e);
        check_val("wb_o.wr", e.wb.wr, wb_o.wr);
        check_val("wb_o.cancel_load", e.wb.cancel_load, wb_o.cancel_load);
        check_val("lsq_o.lq_wr", e.lsq.lq_wr, lsq_o.lq_wr);
        check_val("lsq_o.sq_wr", e.lsq.sq_wr, lsq_o.sq_wr);
        check_val("redirect_o.jump", e.rd.jump, redirect_o.jump);
        check_val("excp_valid_o", e.excp_valid, excp_valid_o);
        check_val("excp_cause_o", e.excp_cause, excp_cause_o);
        if (e.wb.wr) begin
            check_val("wb_o.regd_addr", e.wb.regd_addr, wb_o.regd_addr);
            check_val("wb_o.data", e.wb.data, wb_o.data);
        end
        if (e.lsq.lq_wr || e.lsq.sq_wr) begin
            check_val("lsq_o.funct3", e.lsq.funct3, lsq_o.funct3);
            check_val("lsq_o.regd_addr", e.lsq.regd_addr, lsq_o.regd_addr);
            check_val("lsq_o.data", e.lsq.data, lsq_o.data);
            check_val("lsq_o.addr", e.lsq.addr, lsq_o.addr);
        end
        if (e.rd.jump) begin
            check_val("redirect_o.jump_addr", e.rd.jump_addr, redirect_o.jump_addr);
        end
    endtask

    // the queue front is the registered instruction and the back is the one being accepted
    always @(posedge clk_i) begin
        if (resetb_i) begin
            if (ids_stall_o) begin
                stall_cycles++;
                checks++;
                if (wb_o.wr || wb_o.cancel_load || lsq_o.lq_wr || lsq_o.sq_wr ||
                    redirect_o.jump || excp_valid_o) begin
                    $display("%0t: a commit output is active while the stage stalls", $time);
                    errors++;
                end
            end else begin
                if (wb_o.wr) begin
                    wb_writes++;
                end
                if (expq.size() > 1) begin
                    compare_commit(expq.pop_front());
                end
            end
        end
    end

    // ------------------------------------------------------------
    // driving
    // ------------------------------------------------------------
    task automatic drive_req(input ex_req_t req, input logic full, input int hold);
        int waited;
        @(negedge clk_i);
        ids_req_i = req;
        lsq_full_i = full;
        expq.push_back(ref_commit(req));
        waited = 0;
        @(posedge clk_i);
        while (ids_stall_o) begin
            waited++;
            if (waited > ACCEPT_LIMIT) begin
                $display("timeout: request not accepted after %0d cycles", ACCEPT_LIMIT);
                $display("Done: errors found");
                $finish;
            end else begin
                @(negedge clk_i);
                // queue frees up after hold stalled cycles
                if (waited >= hold) begin
                    lsq_full_i = 1'b0;
                end
                @(posedge clk_i);
            end
        end
    endtask

    task automatic drain();
        drive_req('0, 1'b0, 0);
        @(negedge clk_i);
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
        chk_mark = checks;
        err_mark = errors;
    endtask

    initial begin
        ex_req_t     r;
        logic [31:0] w;
        logic [3:0]  sel;
        int          i;
        int          mark;
        resetb_i = 1'b0;
        lsq_full_i = 1'b0;
        ids_req_i = '0;
        lcg_state = 32'hde0c_46b8;
        errors = 0;
        checks = 0;
        err_mark = 0;
        chk_mark = 0;
        stall_cycles = 0;
        wb_writes = 0;
        model_run = 1'b1;
        model_redirect = 1'b0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        resetb_i = 1'b1;

        // test 1
        for (i = 0; i < 40; i++) begin
            r = rand_req();
            w = lcg_next();
            sel = 4'(w[31:16] % 10);
            r.zone = ZONE_REGFILE;
            r.alu_op = alu_op_e'(sel);
            drive_req(r, 1'b0, 0);
        end
        drain();
        report_test("test 1 random alu ops");

        // test 2 uses small offsets to reach every alignment
        for (i = 0; i < 40; i++) begin
            r = rand_req();
            w = lcg_next();
            if (w[31]) begin
                r.zone = ZONE_STOREQ;
            end else begin
                r.zone = ZONE_LOADQ;
            end
            r.funct3 = (w[30:29] == 2'd0) ? 3'b000 : (w[28] ? `EX_F3_HALF : `EX_F3_WORD);
            r.alu_op = ALU_ADD;
            r.operand_left = r.operand_left & 32'hffff_fff0;
            r.operand_right = {28'd0, w[3:0]};
            drive_req(r, 1'b0, 0);
        end
        drain();
        report_test("test 2 loads and stores");

        // test 3
        for (i = 0; i < 48; i++) begin
            r = rand_req();
            w = lcg_next();
            r.jump = 1'b1;
            r.alu_op = ALU_ADD;
            r.operand_left = r.pc;
            r.operand_right = {20'd0, w[11:2], 2'b00};
            if (w[14:13] == 2'd0) begin
                r.operand_right[1] = 1'b1;
            end
            if (w[15]) begin
                r.cmp_right = r.cmp_left;
            end
            if (i % 4 == 3) begin
                r.link = 1'b1;
                r.zone = ZONE_REGFILE;
                r.ins_size = w[16] ? 2'd2 : 2'd1;
            end else begin
                r.cond = 1'b1;
                r.funct3 = branch_code(i);
            end
            drive_req(r, 1'b0, 0);
            // filler write that is dropped when the branch was taken
            r = rand_req();
            r.zone = ZONE_REGFILE;
            drive_req(r, 1'b0, 0);
        end
        drain();
        report_test("test 3 branches and jumps");

        // test 4
        mark = wb_writes;
        r = rand_req();
        r.jump = 1'b1;
        r.alu_op = ALU_ADD;
        r.operand_left = r.pc;
        r.operand_right = 32'h40;
        drive_req(r, 1'b0, 0);
        for (i = 0; i < 6; i++) begin
            r = rand_req();
            r.zone = ZONE_REGFILE;
            r.sof = (i == 4);
            drive_req(r, 1'b0, 0);
        end
        drain();
        check_val("wb_o.wr count", 2, wb_writes - mark);
        report_test("test 4 wrong-path discard");

        // test 5
        mark = stall_cycles;
        r = rand_req();
        r.zone = ZONE_LOADQ;
        r.funct3 = `EX_F3_WORD;
        r.alu_op = ALU_ADD;
        r.operand_left = r.operand_left & 32'hffff_fff0;
        r.operand_right = 32'h8;
        drive_req(r, 1'b1, 4);
        r = rand_req();
        r.zone = ZONE_REGFILE;
        drive_req(r, 1'b1, 4);
        drain();
        check_val("ids_stall_o cycles", 4, stall_cycles - mark);
        report_test("test 5 back-pressure");

        if (expq.size() != 1) begin
            $display("%0d expected commits were never compared", expq.size() - 1);
            errors++;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/ex_pkg.sv
hw/ex_pipe_reg.sv
hw/ex_alu.sv
hw/ex_flow_fsm.sv
hw/ex_commit.sv
hw/ex_stage_top.sv
verification/ex_stage_tb.sv
